// File: logic/cpuPkg.sv
// Shared definitions for the 8-bit execution datapath.
// Holds the ALU opcodes, operand and register selects, the Wishbone
// register map, status flag positions and the host command word layout.

package cpuPkg;

	// ALU micro-operations, carried in command bits 11 to 8.
	typedef enum logic [3:0] {
		opAdc,
		opSbc,
		opAnd,
		opOra,
		opEor,
		opAsl,
		opLsr,
		opRol,
		opRor,
		opInc,
		opDec,
		opCmp
	} aluOp;

	// Second operand source, carried in command bits 13 and 12.
	typedef enum logic [1:0] {
		srcX,
		srcY,
		srcImm
	} srcSel;

	// Architectural register select.
	// Also matches the low two bits of the host register addresses.
	typedef enum logic [1:0] {
		selA,
		selX,
		selY,
		selS
	} regSel;

	// Wishbone register map.
	localparam logic [2:0] addrA       = 3'd0;
	localparam logic [2:0] addrX       = 3'd1;
	localparam logic [2:0] addrY       = 3'd2;
	localparam logic [2:0] addrS       = 3'd3;
	localparam logic [2:0] addrCommand = 3'd4;
	localparam logic [2:0] addrStatus  = 3'd5;

	// Flag positions, laid out as in the 6502 status byte.
	localparam int flagC = 0;
	localparam int flagZ = 1;
	localparam int flagI = 2;
	localparam int flagD = 3;
	localparam int flagV = 6;
	localparam int flagN = 7;

	// Host command word, most significant field first.
	typedef struct packed {
		regSel      dest;
		srcSel      src;
		aluOp       op;
		logic [7:0] imm;
	} cmdWord;

endpackage

// File: logic/aluBus.sv
// Request and result link between the command sequencer and the ALU.
// The sequencer drives the request side, the ALU answers in the same cycle.

`timescale 1ns/10ps

interface aluBus;
	import cpuPkg::*;

	// Request side.
	aluOp       opcode;
	logic [7:0] operandA;
	logic [7:0] operandB;
	logic       carryIn;
	logic       decimal;

	// Result side.
	logic [7:0] result;
	logic       carryOut;
	logic       overflow;
	logic       halfCarry;

	modport request (
		output opcode, operandA, operandB, carryIn, decimal,
		input  result, carryOut, overflow, halfCarry
	);

	modport compute (
		input  opcode, operandA, operandB, carryIn, decimal,
		output result, carryOut, overflow, halfCarry
	);

endinterface

// File: logic/alu.sv
// Combinational 6502 ALU.
// Binary and BCD add and subtract, logic operations, shifts, rotates,
// increment, decrement and compare. phi2 only clocks the request check.

`timescale 1ns/10ps

module alu (
	input logic    phi2,
	aluBus.compute bus
);
	import cpuPkg::*;

	logic       subtract;
	logic [7:0] addend;
	logic [4:0] loSum;
	logic [4:0] hiSum;
	logic [7:0] binSum;
	logic       loFix;
	logic [8:0] loAdjusted;
	logic       hiFix;
	logic [7:0] decSum;
	logic       decCarry;

	// Subtract and compare add the inverted operand.
	assign subtract = bus.opcode inside {opSbc, opCmp};
	assign addend   = subtract ? ~bus.operandB : bus.operandB;

	// Low nibble first, its carry out is the half carry.
	assign loSum         = {1'b0, bus.operandA[3:0]} + {1'b0, addend[3:0]} + {4'b0, bus.carryIn};
	assign bus.halfCarry = loSum[4];
	// High nibble takes the half carry.
	assign hiSum  = {1'b0, bus.operandA[7:4]} + {1'b0, addend[7:4]} + {4'b0, bus.halfCarry};
	assign binSum = {hiSum[3:0], loSum[3:0]};

	// Decimal adjust for add.
	// Low digit over nine or carried out, add six.
	assign loFix      = bus.halfCarry || (binSum[3:0] > 4'd9);
	assign loAdjusted = {hiSum[4], binSum} + (loFix ? 9'h006 : 9'h000);
	// High digit likewise, after the low correction has rippled in.
	assign hiFix = loAdjusted[8] || (loAdjusted[7:4] > 4'd9);

	always_comb begin
		if (subtract) begin
			// A borrowed digit wraps past nine, so take six back off.
			decSum[3:0] = bus.halfCarry ? binSum[3:0] : binSum[3:0] - 4'd6;
			decSum[7:4] = hiSum[4] ? binSum[7:4] : binSum[7:4] - 4'd6;
			decCarry    = hiSum[4];
		end else begin
			decSum   = loAdjusted[7:0] + (hiFix ? 8'h60 : 8'h00);
			decCarry = hiFix;
		end
	end

	always_comb begin
		// Defaults pass A through and keep the carry.
		bus.result   = bus.operandA;
		bus.carryOut = bus.carryIn;
		bus.overflow = 1'b0;
		case (bus.opcode)
			opAdc, opSbc, opCmp: begin
				bus.result   = bus.decimal ? decSum : binSum;
				bus.carryOut = bus.decimal ? decCarry : hiSum[4];
				// Signed overflow always comes from the binary sum.
				bus.overflow = (bus.operandA[7] == addend[7]) && (binSum[7] != bus.operandA[7]);
			end
			opAnd: bus.result = bus.operandA & bus.operandB;
			opOra: bus.result = bus.operandA | bus.operandB;
			opEor: bus.result = bus.operandA ^ bus.operandB;
			// Shifts push the lost bit into carry.
			opAsl: {bus.carryOut, bus.result} = {bus.operandA, 1'b0};
			opLsr: {bus.result, bus.carryOut} = {1'b0, bus.operandA};
			// Rotates go through carry.
			opRol: {bus.carryOut, bus.result} = {bus.operandA, bus.carryIn};
			opRor: {bus.result, bus.carryOut} = {bus.carryIn, bus.operandA};
			opInc: bus.result = bus.operandA + 8'd1;
			opDec: bus.result = bus.operandA - 8'd1;
			default: ;
		endcase
	end

	// Decimal mode only means something for add and subtract.
	decimalOnlyArith: assert property (
		@(posedge phi2) bus.decimal |-> (bus.opcode inside {opAdc, opSbc})
	) else $error("ALU decimal request with opcode %0d", bus.opcode);

endmodule

// File: logic/registerFile.sv
// Accumulator, X, Y and stack pointer.
// One write port, all four registers readable at once.

`timescale 1ns/10ps

module registerFile #(
	parameter logic [7:0] resetStackPointer = 8'hFF
) (
	input  logic          phi2,
	input  logic          reset,
	input  logic          writeEnable,
	input  cpuPkg::regSel writeSel,
	input  logic [7:0]    writeData,
	output logic [7:0]    regA,
	output logic [7:0]    regX,
	output logic [7:0]    regY,
	output logic [7:0]    regS
);
	import cpuPkg::*;

	always_ff @(posedge phi2) begin
		if (reset) begin
			regA <= 8'h00;
			regX <= 8'h00;
			regY <= 8'h00;
			// Stack pointer comes up at its configured top.
			regS <= resetStackPointer;
		end else if (writeEnable) begin
			case (writeSel)
				selA: regA <= writeData;
				selX: regX <= writeData;
				selY: regY <= writeData;
				selS: regS <= writeData;
				default: ;
			endcase
		end
	end

	// A write must name a real register.
	knownWriteSel: assert property (
		@(posedge phi2) disable iff (reset) writeEnable |-> !$isunknown(writeSel)
	) else $error("Register write with unknown select");

endmodule

// File: logic/statusReg.sv
// Processor status flags N, V, D, I, Z, C.
// Loaded whole by a host write, or bit by bit under a mask from an ALU result.
// Bits 4 and 5 always read one.

`timescale 1ns/10ps

module statusReg (
	input  logic       phi2,
	input  logic       reset,
	input  logic       hostWrite,
	input  logic [7:0] hostData,
	input  logic       aluUpdate,
	input  logic [7:0] aluUpdateMask,
	input  logic       carryIn,
	input  logic       zeroIn,
	input  logic       negativeIn,
	input  logic       overflowIn,
	output logic [7:0] flags
);
	import cpuPkg::*;

	logic [7:0] flagReg;
	logic [7:0] aluFlags;

	// ALU flags placed at their status byte positions.
	always_comb begin
		aluFlags        = 8'h00;
		aluFlags[flagC] = carryIn;
		aluFlags[flagZ] = zeroIn;
		aluFlags[flagV] = overflowIn;
		aluFlags[flagN] = negativeIn;
	end

	always_ff @(posedge phi2) begin
		if (reset) begin
			// Interrupts masked after reset, everything else clear.
			flagReg        <= 8'h00;
			flagReg[flagI] <= 1'b1;
		end else if (hostWrite) begin
			flagReg <= hostData;
		end else if (aluUpdate) begin
			// Only the masked flags change.
			flagReg <= (flagReg & ~aluUpdateMask) | (aluFlags & aluUpdateMask);
		end
	end

	// Unused bits 4 and 5 read as one.
	assign flags = flagReg | 8'h30;

	// The sequencer never loads and updates in one cycle.
	singleFlagSource: assert property (
		@(posedge phi2) disable iff (reset) !(hostWrite && aluUpdate)
	) else $error("Host write and ALU update collide on status");

endmodule

// File: logic/busController.sv
// Wishbone classic slave and command sequencer.
// Register and status accesses ack after one cycle. A command write latches,
// runs the ALU, writes back result and flags and acks after two cycles.

`timescale 1ns/10ps

module busController (
	input  logic          phi2,
	input  logic          reset,
	input  logic          cyc,
	input  logic          stb,
	input  logic          we,
	input  logic [2:0]    adr,
	input  logic [15:0]   datWrite,
	output logic [15:0]   datRead,
	output logic          ack,
	aluBus.request        aluPort,
	output logic          writeEnable,
	output cpuPkg::regSel writeSel,
	output logic [7:0]    writeData,
	output logic          hostWrite,
	output logic [7:0]    hostData,
	output logic          aluUpdate,
	output logic [7:0]    aluUpdateMask,
	output logic          carryIn,
	output logic          zeroIn,
	output logic          negativeIn,
	output logic          overflowIn,
	input  logic [7:0]    regA,
	input  logic [7:0]    regX,
	input  logic [7:0]    regY,
	input  logic [7:0]    regS,
	input  logic [7:0]    flags
);
	import cpuPkg::*;

	typedef enum logic [1:0] {stIdle, stExecute, stDone} ctrlState;

	ctrlState   state;
	cmdWord     cmdReg;
	logic       hostAccess;
	logic       launch;
	logic       executing;
	logic [7:0] destValue;

	// New access seen while idle.
	assign hostAccess = (state == stIdle) && cyc && stb;
	assign launch     = hostAccess && we && (adr == addrCommand);
	assign executing  = state == stExecute;

	always_ff @(posedge phi2) begin
		if (reset) begin
			state <= stIdle;
			ack   <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				stIdle: begin
					if (launch) begin
						state <= stExecute;
					end else if (cyc && stb) begin
						ack   <= 1'b1;
						state <= stDone;
					end
				end
				stExecute: begin
					ack   <= 1'b1;
					state <= stDone;
				end
				// Hold off until the master drops the strobe.
				stDone: if (!(cyc && stb)) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// Command word stays for readback.
	always_ff @(posedge phi2) begin
		if (launch) cmdReg <= cmdWord'(datWrite);
	end

	// Destination register, used as operand A outside the accumulator group.
	always_comb begin
		case (cmdReg.dest)
			selA: destValue = regA;
			selX: destValue = regX;
			selY: destValue = regY;
			default: destValue = regS;
		endcase
	end

	// Operand selection.
	always_comb begin
		aluPort.opcode = cmdReg.op;
		if (cmdReg.op inside {opAdc, opSbc, opAnd, opOra, opEor, opCmp})
			aluPort.operandA = regA;
		else
			aluPort.operandA = destValue;
		case (cmdReg.src)
			srcX: aluPort.operandB = regX;
			srcY: aluPort.operandB = regY;
			default: aluPort.operandB = cmdReg.imm;
		endcase
		// Compare never borrows in.
		aluPort.carryIn = (cmdReg.op == opCmp) ? 1'b1 : flags[flagC];
		aluPort.decimal = flags[flagD] && (cmdReg.op inside {opAdc, opSbc});
	end

	// Register write port, shared by host writes and write-back.
	assign writeEnable = executing ? (cmdReg.op != opCmp) :
		hostAccess && we && (adr inside {addrA, addrX, addrY, addrS});
	assign writeSel  = executing ? cmdReg.dest : regSel'(adr[1:0]);
	assign writeData = executing ? aluPort.result : datWrite[7:0];

	// Status port.
	assign hostWrite  = hostAccess && we && (adr == addrStatus);
	assign hostData   = datWrite[7:0];
	assign aluUpdate  = executing;
	assign carryIn    = aluPort.carryOut;
	assign overflowIn = aluPort.overflow;
	assign zeroIn     = aluPort.result == 8'h00;
	assign negativeIn = aluPort.result[7];

	// Every operation sets N and Z; the rest depends on the group.
	always_comb begin
		aluUpdateMask        = 8'h00;
		aluUpdateMask[flagN] = 1'b1;
		aluUpdateMask[flagZ] = 1'b1;
		case (cmdReg.op)
			opAdc, opSbc: begin
				aluUpdateMask[flagC] = 1'b1;
				aluUpdateMask[flagV] = 1'b1;
			end
			opAsl, opLsr, opRol, opRor, opCmp: aluUpdateMask[flagC] = 1'b1;
			default: ;
		endcase
	end

	// Read mux, upper byte zero except for the command word.
	always_comb begin
		datRead = 16'h0000;
		case (adr)
			addrA: datRead[7:0] = regA;
			addrX: datRead[7:0] = regX;
			addrY: datRead[7:0] = regY;
			addrS: datRead[7:0] = regS;
			addrCommand: datRead = cmdReg;
			addrStatus: datRead[7:0] = flags;
			default: ;
		endcase
	end

	ackSingleCycle: assert property (
		@(posedge phi2) disable iff (reset) ack |=> !ack
	) else $error("Wishbone ack held longer than one cycle");

	// Ack only answers a strobe that was already there.
	ackNeedsStrobe: assert property (
		@(posedge phi2) disable iff (reset) $rose(ack) |-> (cyc && stb && $past(cyc && stb))
	) else $error("Wishbone ack without cyc and stb");

endmodule

// File: logic/datapathTop.sv
// Execution datapath behind a Wishbone classic slave port.
// Wires the command sequencer, ALU, register file and status flags.
// resetStackPointer sets the stack pointer after reset.

`timescale 1ns/10ps

module datapathTop #(
	parameter logic [7:0] resetStackPointer = 8'hFF
) (
	input  logic        phi2,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [2:0]  adr,
	input  logic [15:0] datWrite,
	output logic [15:0] datRead,
	output logic        ack
);
	import cpuPkg::*;

	// Register file port.
	logic       writeEnable;
	regSel      writeSel;
	logic [7:0] writeData;
	logic [7:0] regA;
	logic [7:0] regX;
	logic [7:0] regY;
	logic [7:0] regS;

	// Status port.
	logic       hostWrite;
	logic [7:0] hostData;
	logic       aluUpdate;
	logic [7:0] aluUpdateMask;
	logic       carryIn;
	logic       zeroIn;
	logic       negativeIn;
	logic       overflowIn;
	logic [7:0] flags;

	aluBus aluLink ();

	busController ctrl (.*, .aluPort(aluLink.request));

	alu aluCore (.phi2, .bus(aluLink.compute));

	registerFile #(.resetStackPointer(resetStackPointer)) regs (.*);

	statusReg status (.*);

endmodule

// File: testbench/datapathTb.sv
// Testbench for the Wishbone execution datapath.
// Drives register, status and command accesses, predicts results with a
// reference model of the 6502 ALU rules and checks every readback.

`timescale 1ns/10ps

module datapathTb;
	import cpuPkg::*;

	localparam int clockPeriod = 10;
	localparam logic [7:0] stackTop = 8'hC0;
	localparam int ackLimit = 8;
	// Test lengths, also used to size the watchdog.
	localparam int binaryOps = 24;
	localparam int decimalOps = 16;
	localparam int logicRounds = 2;
	localparam int latencyOps = 6;
	localparam int transactions = 15 + 7 * (binaryOps + decimalOps + 10 * logicRounds)
		+ 1 + 3 * latencyOps;
	localparam int timeoutCycles = transactions * 4 + 100;

	logic        phi2;
	logic        reset;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [2:0]  adr;
	logic [15:0] datWrite;
	logic [15:0] datRead;
	logic        ack;

	// Reference model state.
	logic [7:0]  modelRegs [0:3];
	logic [7:0]  modelFlags;
	logic [15:0] lastCommand;
	logic [31:0] lcgState = 32'd80;
	aluOp        logicOps [0:9] = '{opAnd, opOra, opEor, opAsl, opLsr,
		opRol, opRor, opInc, opDec, opCmp};

	int    errors = 0;
	int    checks = 0;
	int    testsRun = 0;
	int    testsFailed = 0;
	int    errorsAtStart = 0;
	string currentTest = "none";

	datapathTop #(.resetStackPointer(stackTop)) u_dut (.*);

	always #(clockPeriod / 2) phi2 = ~phi2;

	// Ack belongs to an open bus cycle.
	ackInsideCycle: assert property (@(posedge phi2) disable iff (reset) ack |-> (cyc && stb))
	else begin
		$display("Ack was raised outside a bus cycle");
		errors++;
	end

	function automatic logic [7:0] randomByte();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[23:16];
	endfunction

	function automatic logic [7:0] randomBcd();
		logic [7:0] hi;
		logic [7:0] lo;
		hi = randomByte() % 10;
		lo = randomByte() % 10;
		return {hi[3:0], lo[3:0]};
	endfunction

	function automatic int bcdValue(input logic [7:0] value);
		return int'(value[7:4]) * 10 + int'(value[3:0]);
	endfunction

	function automatic logic [7:0] bcdByte(input int value);
		logic [7:0] hi;
		logic [7:0] lo;
		hi = value / 10;
		lo = value % 10;
		return {hi[3:0], lo[3:0]};
	endfunction

	task automatic checkValue(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		valueMatch: assert (actual === expected) else begin
			$display("error %s %s: expected %0h actual %0h", currentTest, what, expected, actual);
			errors++;
		end
	endtask

	// One classic cycle; latency counts edges from strobe to ack.
	task automatic busAccess(input logic write, input logic [2:0] addr, input logic [15:0] data,
		output logic [15:0] readData, output int latency);
		@(posedge phi2);
		cyc      <= 1'b1;
		stb      <= 1'b1;
		we       <= write;
		adr      <= addr;
		datWrite <= data;
		latency = 0;
		do begin
			@(posedge phi2);
			latency++;
			@(negedge phi2);
		end while (!ack && latency < ackLimit);
		if (!ack) begin
			$display("No ack from the DUT for an access to address %0d", addr);
			errors++;
		end
		readData = datRead;
		@(posedge phi2);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic writeRegister(input logic [2:0] addr, input logic [7:0] data);
		logic [15:0] unused;
		int          latency;
		busAccess(1'b1, addr, {8'h00, data}, unused, latency);
		checkValue("write latency", 1, latency);
		if (addr == addrStatus)
			modelFlags = data | 8'h30;
		else
			modelRegs[addr[1:0]] = data;
	endtask

	task automatic readAndCheck(input logic [2:0] addr, input string what);
		logic [15:0] data;
		int          latency;
		busAccess(1'b0, addr, 16'h0000, data, latency);
		checkValue("read latency", 1, latency);
		if (addr == addrStatus)
			checkValue(what, {8'h00, modelFlags}, data);
		else
			checkValue(what, {8'h00, modelRegs[addr[1:0]]}, data);
	endtask

	// Expected result and flags from the 6502 rules.
	task automatic modelCommand(input regSel dest, input srcSel src, input aluOp op,
		input logic [7:0] imm);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] bIn;
		logic [7:0] r;
		logic [8:0] sum;
		logic       carry;
		logic       c;
		logic       v;
		int         dr;
		int         sv;
		carry = modelFlags[flagC];
		a = (op inside {opAdc, opSbc, opAnd, opOra, opEor, opCmp}) ? modelRegs[selA] :
			modelRegs[dest];
		b = (src == srcX) ? modelRegs[selX] : (src == srcY) ? modelRegs[selY] : imm;
		c = carry;
		v = modelFlags[flagV];
		r = a;
		case (op)
			opAdc, opSbc, opCmp: begin
				bIn = (op == opAdc) ? b : ~b;
				sum = {1'b0, a} + {1'b0, bIn} + ((op == opCmp) ? 9'd1 : {8'd0, carry});
				r = sum[7:0];
				c = sum[8];
				// Signed result outside the 8-bit range is an overflow.
				sv = $signed(a);
				if (op == opAdc)
					sv = sv + $signed(b) + int'(carry);
				else
					sv = sv - $signed(b) - ((op == opCmp) ? 0 : 1 - int'(carry));
				v = (sv > 127) || (sv < -128);
				if (modelFlags[flagD] && op != opCmp) begin
					if (op == opAdc) begin
						dr = bcdValue(a) + bcdValue(b) + int'(carry);
						c = dr > 99;
						if (c) dr -= 100;
					end else begin
						dr = bcdValue(a) - bcdValue(b) - (1 - int'(carry));
						c = dr >= 0;
						if (!c) dr += 100;
					end
					r = bcdByte(dr);
				end
			end
			opAnd: r = a & b;
			opOra: r = a | b;
			opEor: r = a ^ b;
			opAsl: {c, r} = {a, 1'b0};
			opLsr: {r, c} = {1'b0, a};
			opRol: {c, r} = {a, carry};
			opRor: {r, c} = {carry, a};
			opInc: r = a + 8'd1;
			opDec: r = a - 8'd1;
			default: ;
		endcase
		modelFlags[flagN] = r[7];
		modelFlags[flagZ] = (r == 8'h00);
		if (op inside {opAdc, opSbc, opCmp, opAsl, opLsr, opRol, opRor}) modelFlags[flagC] = c;
		if (op inside {opAdc, opSbc}) modelFlags[flagV] = v;
		if (op != opCmp) modelRegs[dest] = r;
	endtask

	task automatic issueCommand(input regSel dest, input srcSel src, input aluOp op,
		input logic [7:0] imm);
		logic [15:0] unused;
		int          latency;
		lastCommand = {dest, src, op, imm};
		busAccess(1'b1, addrCommand, lastCommand, unused, latency);
		checkValue("command latency", 2, latency);
		modelCommand(dest, src, op, imm);
	endtask

	// Fresh operands and flags, one command, then destination and status.
	task automatic runOperation(input logic [7:0] a, input logic [7:0] x, input logic [7:0] y,
		input logic [7:0] status, input regSel dest, input srcSel src, input aluOp op,
		input logic [7:0] imm);
		writeRegister(addrA, a);
		writeRegister(addrX, x);
		writeRegister(addrY, y);
		writeRegister(addrStatus, status);
		issueCommand(dest, src, op, imm);
		readAndCheck({1'b0, dest}, "destination");
		readAndCheck(addrStatus, "status");
	endtask

	task automatic startTest(input string name);
		currentTest = name;
		errorsAtStart = errors;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errors != errorsAtStart) testsFailed++;
		$display("test %s: %0d errors", currentTest, errors - errorsAtStart);
	endtask

	initial begin
		#(timeoutCycles * clockPeriod);
		$display("The run timed out after %0d cycles", timeoutCycles);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [15:0] data;
		int          latency;
		aluOp        op;
		regSel       dest;
		phi2     = 1'b0;
		reset    = 1'b1;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = 3'd0;
		datWrite = 16'h0000;
		// State after reset, taken from the register rules.
		modelRegs  = '{8'h00, 8'h00, 8'h00, stackTop};
		modelFlags = 8'h34;
		repeat (3) @(posedge phi2);
		reset <= 1'b0;

		startTest("resetValues");
		readAndCheck(addrA, "A");
		readAndCheck(addrX, "X");
		readAndCheck(addrY, "Y");
		readAndCheck(addrS, "S");
		readAndCheck(addrStatus, "status");
		finishTest();

		startTest("registerAccess");
		for (int i = 0; i < 4; i++) writeRegister(3'(i), randomByte());
		writeRegister(addrStatus, randomByte());
		for (int i = 0; i < 4; i++) readAndCheck(3'(i), "register");
		readAndCheck(addrStatus, "status");
		finishTest();

		startTest("binaryArith");
		for (int i = 0; i < binaryOps; i++) begin
			op = (randomByte() % 2) ? opAdc : opSbc;
			// D stays clear, carry and the other flags are random.
			runOperation(randomByte(), randomByte(), randomByte(), (randomByte() & 8'hC3) | 8'h04,
				selA, srcSel'(2'(randomByte() % 3)), op, randomByte());
		end
		finishTest();

		startTest("decimalArith");
		for (int i = 0; i < decimalOps; i++) begin
			op = (randomByte() % 2) ? opAdc : opSbc;
			runOperation(randomBcd(), randomBcd(), randomBcd(), 8'h08 | (randomByte() & 8'h01),
				selA, srcSel'(2'(randomByte() % 3)), op, randomBcd());
		end
		finishTest();

		startTest("logicShiftCompare");
		for (int round = 0; round < logicRounds; round++) begin
			foreach (logicOps[i]) begin
				op = logicOps[i];
				dest = (op inside {opAnd, opOra, opEor, opCmp}) ? selA : regSel'(2'(randomByte()));
				// Random flags show which ones each group leaves alone.
				runOperation(randomByte(), randomByte(), randomByte(), randomByte(), dest,
					srcSel'(2'(randomByte() % 3)), op, randomByte());
			end
		end
		finishTest();

		startTest("commandLatency");
		writeRegister(addrA, randomByte());
		for (int i = 0; i < latencyOps; i++) begin
			issueCommand(selA, srcImm, (i % 2) ? opInc : opAsl, randomByte());
			readAndCheck(addrA, "A after command");
			busAccess(1'b0, addrCommand, 16'h0000, data, latency);
			checkValue("command word", lastCommand, data);
		end
		finishTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sources.f
logic/cpuPkg.sv
logic/aluBus.sv
logic/alu.sv
logic/registerFile.sv
logic/statusReg.sv
logic/busController.sv
logic/datapathTop.sv
testbench/datapathTb.sv
